// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module tb_eeprom_wr -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== hw/bus_phase_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eeprom_defs.svh"

module bus_phase_timer (
  input  wire  clk,
  input  wire  rst_n,
  input  logic run,
  output logic scl,
  output logic low_mid,
  output logic rise,
  output logic high_mid,
  output logic fall
);

  localparam int PH_W = $clog2(`EEPROM_PHASE_CLKS + 1);

  logic [PH_W-1:0] phase_cnt;
  logic [1:0]      quarter;   // 0 low_mid, 1 rise, 2 high_mid, 3 fall
  logic            running;   // run delayed, keeps strobes off the run path
  logic            tick;

  assign tick = running && (phase_cnt == PH_W'(`EEPROM_PHASE_CLKS - 1));

  assign low_mid  = tick && (quarter == 2'd0);
  assign rise     = tick && (quarter == 2'd1);
  assign high_mid = tick && (quarter == 2'd2);
  assign fall     = tick && (quarter == 2'd3);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running   <= 1'b0;
      phase_cnt <= '0;
      quarter   <= 2'd0;
    end else begin
      running <= run;
      if (!run || !running) begin
        phase_cnt <= '0;
        quarter   <= 2'd0;
      end else if (tick) begin
        phase_cnt <= '0;
        quarter   <= quarter + 2'd1;
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
    end
  end

  // scl parks high when idle, so start and stop see it high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scl <= 1'b1;
    end else if (!run) begin
      scl <= 1'b1;
    end else if (rise) begin
      scl <= 1'b1;
    end else if (fall) begin
      scl <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/eeprom_pkg.sv ====
`default_nettype none

`include "eeprom_defs.svh"

package eeprom_pkg;

  // main sequencer states, one-hot
  typedef enum logic [9:0] {
    st_idle        = 10'b00_0000_0001,
    st_write_start = 10'b00_0000_0010,
    st_ctrl_write  = 10'b00_0000_0100,
    st_addr_write  = 10'b00_0000_1000,
    st_data_write  = 10'b00_0001_0000,
    st_read_start  = 10'b00_0010_0000,
    st_ctrl_read   = 10'b00_0100_0000,
    st_data_read   = 10'b00_1000_0000,
    st_stop        = 10'b01_0000_0000,
    st_ackn        = 10'b10_0000_0000
  } seq_state_e;

  typedef struct packed {
    logic [3:0] dev_code;
    logic [`EEPROM_ADDR_W-`EEPROM_DATA_W-1:0] block; // address bits 10:8
    logic       rnw;
  } ctrl_fields_t;

  // control byte, raw on the wire or split into its fields
  typedef union packed {
    logic [`EEPROM_DATA_W-1:0] raw;
    ctrl_fields_t              fields;
  } ctrl_byte_u;

  typedef struct packed {
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic [`EEPROM_DATA_W-1:0] rdata;
    logic                      nack;
  } host_rsp_t;

  typedef enum logic [2:0] {
    sh_none,
    sh_start,
    sh_stop,
    sh_send, // 8 bits out, then ack slot
    sh_recv  // 8 bits in, then no-ack slot
  } shift_cmd_e;

endpackage

`default_nettype wire

// ==== hw/eeprom_seq_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_seq_fsm (
  input  wire                          clk,
  input  wire                          rst_n,
  input  logic                         wr,
  input  logic                         rd,
  input  eeprom_pkg::host_req_t        req,
  input  logic                         low_mid,
  output logic                         run,
  output eeprom_pkg::shift_cmd_e       cmd,
  output logic [`EEPROM_DATA_W-1:0]    tx_byte,
  input  logic                         done,
  input  logic [`EEPROM_DATA_W-1:0]    rx_byte,
  input  logic                         ack_bit,
  output logic                         ack,
  output eeprom_pkg::host_rsp_t        rsp
);

  eeprom_pkg::seq_state_e state;
  eeprom_pkg::host_req_t  req_q;
  eeprom_pkg::ctrl_byte_u ctrl;
  logic                   is_read;
  logic                   issued;  // command for this state already sent
  logic                   nack_q;

  // timer stops right at the final fall so scl stays high after stop
  assign run = (state != eeprom_pkg::st_idle) && (state != eeprom_pkg::st_ackn) &&
               !((state == eeprom_pkg::st_stop) && done);

  assign ack = (state == eeprom_pkg::st_ackn);

  always_comb begin
    ctrl.fields.dev_code = `EEPROM_DEV_CODE;
    ctrl.fields.block    = req_q.addr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W];
    ctrl.fields.rnw      = (state == eeprom_pkg::st_ctrl_read);
  end

  always_comb begin
    case (state)
      eeprom_pkg::st_ctrl_write,
      eeprom_pkg::st_ctrl_read:  tx_byte = ctrl.raw;
      eeprom_pkg::st_addr_write: tx_byte = req_q.addr[`EEPROM_DATA_W-1:0];
      eeprom_pkg::st_data_write: tx_byte = req_q.wdata;
      default:                   tx_byte = '0;
    endcase
  end

  // one command per state, launched at the first low_mid
  always_comb begin
    cmd = eeprom_pkg::sh_none;
    if (low_mid && !issued) begin
      case (state)
        eeprom_pkg::st_write_start,
        eeprom_pkg::st_read_start: cmd = eeprom_pkg::sh_start;
        eeprom_pkg::st_ctrl_write,
        eeprom_pkg::st_addr_write,
        eeprom_pkg::st_data_write,
        eeprom_pkg::st_ctrl_read:  cmd = eeprom_pkg::sh_send;
        eeprom_pkg::st_data_read:  cmd = eeprom_pkg::sh_recv;
        eeprom_pkg::st_stop:       cmd = eeprom_pkg::sh_stop;
        default:                   cmd = eeprom_pkg::sh_none;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == eeprom_pkg::st_idle) && (wr || rd)) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= eeprom_pkg::st_idle;
      is_read <= 1'b0;
      issued  <= 1'b0;
      nack_q  <= 1'b0;
      rsp     <= '0;
    end else begin
      if (cmd != eeprom_pkg::sh_none) begin
        issued <= 1'b1;
      end else if (done) begin
        issued <= 1'b0;
      end

      case (state)
        eeprom_pkg::st_idle: begin
          if (wr || rd) begin
            is_read <= !wr; // wr wins a tie
            nack_q  <= 1'b0;
            state   <= eeprom_pkg::st_write_start;
          end
        end
        eeprom_pkg::st_write_start: begin
          if (done) state <= eeprom_pkg::st_ctrl_write;
        end
        eeprom_pkg::st_ctrl_write: begin
          if (done && ack_bit) begin
            nack_q <= 1'b1;
            state  <= eeprom_pkg::st_stop;
          end else if (done) begin
            state <= eeprom_pkg::st_addr_write;
          end
        end
        eeprom_pkg::st_addr_write: begin
          if (done && ack_bit) begin
            nack_q <= 1'b1;
            state  <= eeprom_pkg::st_stop;
          end else if (done) begin
            state <= is_read ? eeprom_pkg::st_read_start : eeprom_pkg::st_data_write;
          end
        end
        eeprom_pkg::st_data_write: begin
          if (done) begin
            nack_q <= ack_bit;
            state  <= eeprom_pkg::st_stop;
          end
        end
        eeprom_pkg::st_read_start: begin
          if (done) state <= eeprom_pkg::st_ctrl_read; // repeated start
        end
        eeprom_pkg::st_ctrl_read: begin
          if (done && ack_bit) begin
            nack_q <= 1'b1;
            state  <= eeprom_pkg::st_stop;
          end else if (done) begin
            state <= eeprom_pkg::st_data_read;
          end
        end
        eeprom_pkg::st_data_read: begin
          if (done) state <= eeprom_pkg::st_stop;
        end
        eeprom_pkg::st_stop: begin
          if (done) begin
            rsp.nack <= nack_q;
            if (is_read && !nack_q) rsp.rdata <= rx_byte; // shifter still holds it
            state <= eeprom_pkg::st_ackn;
          end
        end
        eeprom_pkg::st_ackn: begin
          state <= eeprom_pkg::st_idle;
        end
        default: begin
          state <= eeprom_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/eeprom_wr.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_wr (
  input  wire                    clk,
  input  wire                    rst_n,
  input  logic                   wr,
  input  logic                   rd,
  input  eeprom_pkg::host_req_t  req,
  output logic                   ack,
  output eeprom_pkg::host_rsp_t  rsp,
  output logic                   scl,
  inout  wire                    sda
);

  logic                         run;
  logic                         low_mid;
  logic                         high_mid;
  logic                         fall;
  eeprom_pkg::shift_cmd_e       cmd;
  logic [`EEPROM_DATA_W-1:0]    tx_byte;
  logic [`EEPROM_DATA_W-1:0]    rx_byte;
  logic                         done;
  logic                         ack_bit;

  bus_phase_timer i_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .scl      (scl),
    .low_mid  (low_mid),
    .rise     (),
    .high_mid (high_mid),
    .fall     (fall)
  );

  eeprom_seq_fsm i_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .rd       (rd),
    .req      (req),
    .low_mid  (low_mid),
    .run      (run),
    .cmd      (cmd),
    .tx_byte  (tx_byte),
    .done     (done),
    .rx_byte  (rx_byte),
    .ack_bit  (ack_bit),
    .ack      (ack),
    .rsp      (rsp)
  );

  sda_shifter i_shift (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .tx_byte  (tx_byte),
    .low_mid  (low_mid),
    .high_mid (high_mid),
    .fall     (fall),
    .sda      (sda),
    .done     (done),
    .rx_byte  (rx_byte),
    .ack_bit  (ack_bit)
  );

endmodule

`default_nettype wire

// ==== hw/sda_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eeprom_defs.svh"

module sda_shifter (
  input  wire                        clk,
  input  wire                        rst_n,
  input  eeprom_pkg::shift_cmd_e     cmd,
  input  logic [`EEPROM_DATA_W-1:0]  tx_byte,
  input  logic                       low_mid,
  input  logic                       high_mid,
  input  logic                       fall,
  inout  wire                        sda,
  output logic                       done,
  output logic [`EEPROM_DATA_W-1:0]  rx_byte,
  output logic                       ack_bit
);

  localparam int CNT_W = $clog2(`EEPROM_DATA_W + 1);

  eeprom_pkg::shift_cmd_e    op;
  logic [CNT_W-1:0]          bit_cnt;  // data bits finished, 8 means ack slot
  logic [`EEPROM_DATA_W-1:0] sh_out;
  logic [`EEPROM_DATA_W-1:0] sh_in;
  logic                      sda_low;
  logic                      ack_slot;
  logic                      one_slot;

  assign sda = sda_low ? 1'b0 : 1'bz; // open drain, high comes from the pullup

  assign ack_slot = (bit_cnt == CNT_W'(`EEPROM_DATA_W));
  assign one_slot = (op == eeprom_pkg::sh_start) || (op == eeprom_pkg::sh_stop);

  assign done = fall && (one_slot ||
                         (((op == eeprom_pkg::sh_send) || (op == eeprom_pkg::sh_recv)) &&
                          ack_slot));

  assign rx_byte = sh_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op      <= eeprom_pkg::sh_none;
      bit_cnt <= '0;
      sda_low <= 1'b0;
      ack_bit <= 1'b1;
    end else begin
      if (low_mid) begin
        if (cmd != eeprom_pkg::sh_none) begin
          op      <= cmd;
          bit_cnt <= '0;
          case (cmd)
            eeprom_pkg::sh_stop: sda_low <= 1'b1;  // low before scl rises
            eeprom_pkg::sh_send: sda_low <= ~tx_byte[`EEPROM_DATA_W-1];
            default:             sda_low <= 1'b0;  // start and recv release
          endcase
        end else if (op == eeprom_pkg::sh_send) begin
          sda_low <= ack_slot ? 1'b0 : ~sh_out[`EEPROM_DATA_W-1];
        end
      end

      if (high_mid) begin
        case (op)
          eeprom_pkg::sh_start: sda_low <= 1'b1; // falling sda with scl high
          eeprom_pkg::sh_stop:  sda_low <= 1'b0; // rising sda with scl high
          eeprom_pkg::sh_send:  if (ack_slot) ack_bit <= sda;
          default: ;
        endcase
      end

      if (done) begin
        op <= eeprom_pkg::sh_none;
      end else if (fall && !ack_slot &&
                   ((op == eeprom_pkg::sh_send) || (op == eeprom_pkg::sh_recv))) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // shift registers, MSB first
  always_ff @(posedge clk) begin
    if (low_mid) begin
      if (cmd == eeprom_pkg::sh_send) begin
        sh_out <= {tx_byte[`EEPROM_DATA_W-2:0], 1'b0};
      end else if ((cmd == eeprom_pkg::sh_none) && (op == eeprom_pkg::sh_send) && !ack_slot) begin
        sh_out <= {sh_out[`EEPROM_DATA_W-2:0], 1'b0};
      end
    end
    if (high_mid && (op == eeprom_pkg::sh_recv) && !ack_slot) begin
      sh_in <= {sh_in[`EEPROM_DATA_W-2:0], sda};
    end
  end

endmodule

`default_nettype wire

// ==== include/eeprom_defs.svh ====
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// 24C16 style part: 2 Kbyte, 11-bit byte address
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

// upper nibble of every control byte
`define EEPROM_DEV_CODE 4'b1010

// clk cycles per quarter bit slot, any value >= 1
`define EEPROM_PHASE_CLKS 1

`endif

// ==== verif/eeprom_bus_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eeprom_defs.svh"

module eeprom_bus_model (
  input  wire  scl,
  inout  wire  sda,
  input  logic refuse
);

  typedef enum logic [2:0] {
    ph_idle,
    ph_ctrl,
    ph_addr,
    ph_data,
    ph_read
  } phase_e;

  logic [`EEPROM_DATA_W-1:0] mem [0:(1 << `EEPROM_ADDR_W)-1];

  phase_e                    phase = ph_idle;
  logic [3:0]                bit_cnt = 4'd0;  // scl rises seen in this byte, 9 = ack slot
  logic [`EEPROM_DATA_W-1:0] shreg = '0;
  logic [`EEPROM_DATA_W-1:0] out_byte = '0;
  logic [`EEPROM_ADDR_W-1:0] ptr = '0;
  logic                      drive_low = 1'b0;
  logic                      to_read = 1'b0;
  logic                      scl_q = 1'b1;
  logic                      sda_q = 1'b1;
  eeprom_pkg::ctrl_byte_u    ctrl;
  integer                    seed;
  integer                    i;
  integer                    tmp;

  assign sda = drive_low ? 1'b0 : 1'bz;

  initial begin
    seed = 65296;
    for (i = 0; i < (1 << `EEPROM_ADDR_W); i = i + 1) begin
      tmp = $random(seed);
      mem[i] = tmp[7:0];
    end
  end

  // byte finished, decide on the acknowledge
  task accept_byte;
    logic ack_it;
    begin
      ack_it = !refuse;
      ctrl.raw = shreg;
      case (phase)
        ph_ctrl: begin
          if (ctrl.fields.dev_code != `EEPROM_DEV_CODE) ack_it = 1'b0;
          if (ack_it) begin
            to_read = ctrl.fields.rnw;
            ptr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W] = ctrl.fields.block;
          end
        end
        ph_addr: if (ack_it) ptr[`EEPROM_DATA_W-1:0] = shreg;
        ph_data: if (ack_it) mem[ptr] = shreg;
        default: ;
      endcase
      if (ack_it) drive_low = 1'b1;
      else phase = ph_idle;
    end
  endtask

  task on_rise;
    begin
      if ((phase != ph_idle) && (bit_cnt < 4'd9)) begin
        if ((phase != ph_read) && (bit_cnt < 4'd8)) shreg = {shreg[6:0], sda};
        bit_cnt = bit_cnt + 4'd1;
      end
    end
  endtask

  task on_fall;
    begin
      if (phase == ph_read) begin
        if ((bit_cnt >= 4'd1) && (bit_cnt <= 4'd7)) begin
          drive_low = !out_byte[3'd7 - bit_cnt[2:0]];
        end else if (bit_cnt == 4'd8) begin
          drive_low = 1'b0; // host answers no-ack
        end else if (bit_cnt == 4'd9) begin
          phase = ph_idle;
        end
      end else if (phase != ph_idle) begin
        if (bit_cnt == 4'd8) begin
          accept_byte();
        end else if (bit_cnt == 4'd9) begin
          drive_low = 1'b0;
          bit_cnt = 4'd0;
          case (phase)
            ph_ctrl: begin
              if (to_read) begin
                phase = ph_read;
                out_byte = mem[ptr];
                drive_low = !out_byte[7];
              end else begin
                phase = ph_addr;
              end
            end
            ph_addr: phase = ph_data;
            default: phase = ph_idle; // no page writes
          endcase
        end
      end
    end
  endtask

  always @(scl or sda) begin
    if (scl !== scl_q) begin
      if (scl === 1'b1) on_rise();
      else if (scl === 1'b0) on_fall();
    end else if ((scl === 1'b1) && (sda !== sda_q)) begin
      if (sda === 1'b0) begin // start or repeated start
        phase = ph_ctrl;
        bit_cnt = 4'd0;
        drive_low = 1'b0;
      end else if (sda === 1'b1) begin
        phase = ph_idle; // stop
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

`default_nettype wire

// ==== verif/tb_eeprom_wr.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eeprom_defs.svh"

module tb_eeprom_wr;

  localparam int N_TRANS  = 29;
  localparam int SLOT_NS  = 4 * 4 * `EEPROM_PHASE_CLKS;
  localparam int LIMIT_NS = N_TRANS * 40 * SLOT_NS + 5000;
  localparam int MEM_SIZE = 1 << `EEPROM_ADDR_W;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  wr;
  logic                  rd;
  logic                  refuse;
  eeprom_pkg::host_req_t req;
  logic                  ack;
  eeprom_pkg::host_rsp_t rsp;
  wire                   scl;
  wire                   sda;

  logic [7:0] ref_mem [0:MEM_SIZE-1];
  logic [7:0] last_rdata;
  integer     seed;
  integer     errors = 0;
  integer     checks = 0;
  integer     test_errs = 0;
  integer     n_req = 0;
  integer     ack_count = 0;

  pullup (sda);

  eeprom_wr i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .req   (req),
    .ack   (ack),
    .rsp   (rsp),
    .scl   (scl),
    .sda   (sda)
  );

  eeprom_bus_model i_mem (
    .scl    (scl),
    .sda    (sda),
    .refuse (refuse)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (ack === 1'b1) ack_count <= ack_count + 1;
  end

  initial begin
    #(LIMIT_NS);
    $display("run timed out waiting for the controller to finish");
    $display("Some tests failed");
    $finish;
  end

  task automatic check_rsp(input eeprom_pkg::host_rsp_t got, input eeprom_pkg::host_rsp_t exp,
                           input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error at %0t ns: %s rsp rdata 0x%h nack %b, expected rdata 0x%h nack %b",
               $time, what, got.rdata, got.nack, exp.rdata, exp.nack);
    end
  endtask

  task automatic check_mem(input logic [7:0] got, input logic [7:0] exp,
                           input logic [10:0] addr);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error at %0t ns: memory at 0x%h holds 0x%h, expected 0x%h",
               $time, addr, got, exp);
    end
  endtask

  // one request with optional stray strobes while it runs
  task automatic run_req(input logic do_wr, input logic do_rd, input logic [10:0] addr,
                         input logic [7:0] data, input logic stray,
                         output eeprom_pkg::host_rsp_t got);
    @(posedge clk);
    wr <= do_wr;
    rd <= do_rd;
    req.addr <= addr;
    req.wdata <= data;
    @(posedge clk);
    wr <= 1'b0;
    rd <= 1'b0;
    n_req = n_req + 1;
    if (stray) begin
      repeat (20) @(posedge clk);
      wr <= 1'b1;
      rd <= 1'b1;
      req.addr <= ~addr; // another request that must be ignored
      req.wdata <= ~data;
      @(posedge clk);
      wr <= 1'b0;
      rd <= 1'b0;
    end
    do @(posedge clk); while (ack !== 1'b1);
    got = rsp;
  endtask

  task automatic report(input string name);
    if (errors == test_errs) $display("test %-16s ok", name);
    else $display("test %-16s failed with %0d errors", name, errors - test_errs);
    test_errs = errors;
  endtask

  task automatic write_check(input logic [10:0] a, input logic [7:0] d, input logic both,
                             input logic stray);
    eeprom_pkg::host_rsp_t got;
    eeprom_pkg::host_rsp_t exp;
    run_req(1'b1, both, a, d, stray, got);
    ref_mem[a] = d;
    exp.rdata = last_rdata;
    exp.nack = 1'b0;
    check_rsp(got, exp, "write");
    check_mem(i_mem.mem[a], ref_mem[a], a);
  endtask

  task automatic read_check(input logic [10:0] a, input logic stray);
    eeprom_pkg::host_rsp_t got;
    eeprom_pkg::host_rsp_t exp;
    run_req(1'b0, 1'b1, a, 8'h00, stray, got);
    last_rdata = ref_mem[a];
    exp.rdata = ref_mem[a];
    exp.nack = 1'b0;
    check_rsp(got, exp, "read");
  endtask

  initial begin
    eeprom_pkg::host_rsp_t got;
    eeprom_pkg::host_rsp_t exp;
    logic [10:0]           a;
    logic [7:0]            d;
    integer                i;
    integer                tmp;
    seed = 65296;
    wr = 1'b0;
    rd = 1'b0;
    refuse = 1'b0;
    req = '0;
    rst_n = 1'b0;
    last_rdata = 8'h00;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (i = 0; i < MEM_SIZE; i = i + 1) ref_mem[i] = i_mem.mem[i];

    for (i = 0; i < 8; i = i + 1) begin
      tmp = $random(seed);
      a = tmp[10:0];
      tmp = $random(seed);
      write_check(a, tmp[7:0], 1'b0, 1'b0);
    end
    report("random writes");

    for (i = 0; i < 8; i = i + 1) begin // one read per block
      tmp = $random(seed);
      read_check({i[2:0], tmp[7:0]}, 1'b0);
    end
    report("random reads");

    for (i = 0; i < 4; i = i + 1) begin
      tmp = $random(seed);
      a = tmp[10:0];
      tmp = $random(seed);
      write_check(a, tmp[7:0], 1'b0, 1'b0);
      read_check(a, 1'b0);
    end
    report("write then read");

    @(posedge clk);
    refuse <= 1'b1;
    tmp = $random(seed);
    a = tmp[10:0];
    d = ~ref_mem[a];
    exp.rdata = last_rdata;
    exp.nack = 1'b1;
    run_req(1'b1, 1'b0, a, d, 1'b0, got);
    check_rsp(got, exp, "refused write");
    check_mem(i_mem.mem[a], ref_mem[a], a);
    run_req(1'b0, 1'b1, a, 8'h00, 1'b0, got);
    check_rsp(got, exp, "refused read");
    @(posedge clk);
    refuse <= 1'b0;
    report("no acknowledge");

    tmp = $random(seed);
    a = tmp[10:0];
    tmp = $random(seed);
    write_check(a, tmp[7:0], 1'b1, 1'b0); // wr and rd together
    tmp = $random(seed);
    a = tmp[10:0];
    tmp = $random(seed);
    write_check(a, tmp[7:0], 1'b0, 1'b1);
    read_check(a, 1'b1);
    repeat (200) @(posedge clk);
    checks = checks + 1;
    if (ack_count != n_req) begin
      errors = errors + 1;
      $display("** Error at %0t ns: %0d acks seen for %0d requests", $time, ack_count, n_req);
    end
    report("strobes");

    $display("%0d checks passed, %0d checks failed", checks - errors, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
hw/eeprom_pkg.sv
hw/bus_phase_timer.sv
hw/eeprom_seq_fsm.sv
hw/sda_shifter.sv
hw/eeprom_wr.sv
verif/eeprom_bus_model.sv
verif/tb_eeprom_wr.sv
